// ==== design/qla_pkg.sv ====
/* shared definitions for the motor controller register core
   address fields, register offsets, status bit positions */
`default_nettype none

package qla_pkg;

    typedef logic [15:0] addr_t;   // register address
    typedef logic [31:0] data_t;   // register data
    typedef logic [15:0] adc_t;    // adc or dac sample
    typedef logic [3:0]  chan_t;   // channel field, addr[7:4]

    // address space, addr[15:12]
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'd0
    } space_e;

    localparam int NUM_AXES = 4;   // axis channels 1..NUM_AXES

    // --------------------------------------------------
    // channel 0 board register offsets, addr[3:0]
    typedef enum logic [3:0] {
        REG_STATUS  = 4'd0,
        REG_VERSION = 4'd4
    } board_off_e;

    // per-axis register offsets, addr[3:0]
    typedef enum logic [3:0] {
        OFF_ADC_DATA = 4'd0,
        OFF_DAC_CTRL = 4'd1
    } axis_off_e;

    localparam data_t FW_VERSION = 32'h514C4131;  // "QLA1"

    // --------------------------------------------------
    // status register bit positions (lsb of each field)
    localparam int STAT_BOARD_ID = 24;  // [27:24], read only
    localparam int STAT_PWR_MASK = 19;  // write mask for pwr enable
    localparam int STAT_PWR_EN   = 18;
    localparam int STAT_AMP_MASK = 8;   // [11:8] on write
    localparam int STAT_SAFETY   = 8;   // [11:8] on read
    localparam int STAT_AMP_EN   = 0;   // [3:0]

endpackage

`default_nettype wire

// ==== design/reg_bus_if.sv ====
/* internal register bus between the host arbiter and the register blocks
   zero-latency reads, single-cycle write strobe */
`timescale 1ns/1ns
`default_nettype none

interface reg_bus_if import qla_pkg::*; (
    input logic sysclk
);

    logic  wen;          // write strobe, one cycle per write
    addr_t waddr;
    data_t wdata;
    addr_t raddr;        // read address, data returned same cycle
    data_t chan0_rdata;  // board register read data
    data_t axis_rdata;   // axis register read data

    // arbiter drives the bus, collects read data
    modport arb (
        output wen, waddr, wdata, raddr,
        input  chan0_rdata, axis_rdata
    );

    modport board (
        input  sysclk, wen, waddr, wdata, raddr,
        output chan0_rdata
    );

    modport axis (
        input  sysclk, wen, waddr, wdata, raddr,
        output axis_rdata
    );

endinterface

`default_nettype wire

// ==== design/host_arbiter.sv ====
/* merges the serial-link and network hosts onto the register bus
   and routes read data back by address space and channel */
`timescale 1ns/1ns
`default_nettype none

module host_arbiter import qla_pkg::*; (
    input  logic  sysclk,

    // serial-link host
    input  logic  fw_wen,
    input  addr_t fw_waddr,
    input  data_t fw_wdata,
    input  addr_t fw_raddr,

    // network host
    input  logic  eth_wen,
    input  addr_t eth_waddr,
    input  data_t eth_wdata,
    input  addr_t eth_raddr,
    input  logic  eth_read_en,  // level, network host owns raddr

    output data_t reg_rdata,    // shared by both hosts

    reg_bus_if.arb bus
);

    chan_t rchan;  // channel of current read

    // --------------------------------------------------
    // write path
    // network host wins a same-cycle collision, serial write is dropped
    assign bus.waddr = eth_wen ? eth_waddr : fw_waddr;
    assign bus.wdata = eth_wen ? eth_wdata : fw_wdata;
    assign bus.wen   = fw_wen | eth_wen;

    // --------------------------------------------------
    // read path
    assign bus.raddr = eth_read_en ? eth_raddr : fw_raddr;
    assign rchan     = bus.raddr[7:4];

    always_comb begin
        reg_rdata = '0;                          // unmapped reads return zero
        if (bus.raddr[15:12] == ADDR_MAIN) begin
            if (rchan == chan_t'(0))
                reg_rdata = bus.chan0_rdata;     // board registers
            else if (rchan <= chan_t'(NUM_AXES))
                reg_rdata = bus.axis_rdata;      // axis 1..4
        end
    end

    // a write strobe must come with a clean address from whichever host won
    a_waddr_known: assert property (
        @(posedge sysclk) bus.wen |-> !$isunknown(bus.waddr)
    ) else $error("register write with unknown address");

endmodule

`default_nettype wire

// ==== design/board_regs.sv ====
/* channel 0 board registers: status, power and amplifier enables, version
   amp outputs are gated by power and by the per-axis safety latches */
`timescale 1ns/1ns
`default_nettype none

module board_regs import qla_pkg::*; (
    input  logic                rst,
    input  logic [3:0]          wenid,           // rotary switch, read inverted
    input  logic [NUM_AXES-1:0] safety_disable,  // latched trips per axis
    output logic                pwr_en,
    output logic [NUM_AXES-1:0] amp_en,
    output logic [NUM_AXES-1:0] clear_disable,   // one-cycle pulse per axis

    reg_bus_if.board bus
);

    logic [NUM_AXES-1:0] amp_en_r;   // raw amp enables, before gating
    logic                status_wen;
    logic                pwr_set;    // write turns power on
    logic [NUM_AXES-1:0] amp_set;    // write turns these amps on
    data_t               status_word;

    assign status_wen = bus.wen
                      && (bus.waddr[15:12] == ADDR_MAIN)
                      && (bus.waddr[7:4] == 4'd0)
                      && (bus.waddr[3:0] == REG_STATUS);

    assign pwr_set = bus.wdata[STAT_PWR_MASK] & bus.wdata[STAT_PWR_EN];
    assign amp_set = bus.wdata[STAT_AMP_MASK +: NUM_AXES]
                   & bus.wdata[STAT_AMP_EN +: NUM_AXES];

    // --------------------------------------------------
    // enable registers
    always_ff @(posedge bus.sysclk) begin
        if (rst) begin
            pwr_en        <= 1'b0;
            amp_en_r      <= '0;
            clear_disable <= '0;
        end else begin
            clear_disable <= '0;
            if (status_wen) begin
                if (bus.wdata[STAT_PWR_MASK])
                    pwr_en <= bus.wdata[STAT_PWR_EN];
                for (int i = 0; i < NUM_AXES; i++) begin
                    if (bus.wdata[STAT_AMP_MASK + i])           // masked bits only
                        amp_en_r[i] <= bus.wdata[STAT_AMP_EN + i];
                end
                // power on re-arms every axis
                clear_disable <= {NUM_AXES{pwr_set}} | amp_set;
            end
        end
    end

    assign amp_en = amp_en_r & {NUM_AXES{pwr_en}} & ~safety_disable;

    // --------------------------------------------------
    // read mux
    always_comb begin
        status_word = '0;
        status_word[STAT_BOARD_ID +: 4]        = ~wenid;
        status_word[STAT_PWR_EN]               = pwr_en;
        status_word[STAT_SAFETY +: NUM_AXES]   = safety_disable;
        status_word[STAT_AMP_EN +: NUM_AXES]   = amp_en_r;      // raw, not gated
    end

    always_comb begin
        case (board_off_e'(bus.raddr[3:0]))
            REG_STATUS:  bus.chan0_rdata = status_word;
            REG_VERSION: bus.chan0_rdata = FW_VERSION;
            default:     bus.chan0_rdata = '0;
        endcase
    end

    // no amplifier drive without board power
    a_amp_needs_pwr: assert property (
        @(posedge bus.sysclk) disable iff (rst) !pwr_en |-> (amp_en == '0)
    ) else $error("amplifier enabled while power is off");

endmodule

`default_nettype wire

// ==== design/axis_regs.sv ====
/* per-axis registers, channels 1..NUM_AXES
   dac current commands are written here, adc feedback is read back */
`timescale 1ns/1ns
`default_nettype none

module axis_regs import qla_pkg::*; (
    input  logic                 rst,
    input  adc_t [NUM_AXES-1:0]  cur_fb,   // current feedback
    input  adc_t [NUM_AXES-1:0]  pot_fb,   // pot feedback
    output adc_t [NUM_AXES-1:0]  cur_cmd,  // dac current commands

    reg_bus_if.axis bus
);

    localparam int IDX_W = $clog2(NUM_AXES);

    chan_t            wchan;
    chan_t            rchan;
    logic [IDX_W-1:0] widx;   // axis n lives at index n-1
    logic [IDX_W-1:0] ridx;
    logic             dac_wen;

    assign wchan = bus.waddr[7:4];
    assign rchan = bus.raddr[7:4];
    assign widx  = IDX_W'(wchan - chan_t'(1));
    assign ridx  = IDX_W'(rchan - chan_t'(1));

    assign dac_wen = bus.wen
                   && (bus.waddr[15:12] == ADDR_MAIN)
                   && (wchan != chan_t'(0))
                   && (wchan <= chan_t'(NUM_AXES))
                   && (bus.waddr[3:0] == OFF_DAC_CTRL);

    // --------------------------------------------------
    // dac command registers
    always_ff @(posedge bus.sysclk) begin
        if (rst) begin
            cur_cmd <= '0;                       // zero current out of reset
        end else if (dac_wen) begin
            cur_cmd[widx] <= bus.wdata[15:0];
        end
    end

    // --------------------------------------------------
    // readback, channel range is checked by the arbiter
    always_comb begin
        case (axis_off_e'(bus.raddr[3:0]))
            OFF_ADC_DATA: bus.axis_rdata = {pot_fb[ridx], cur_fb[ridx]};
            OFF_DAC_CTRL: bus.axis_rdata = {16'h0000, cur_cmd[ridx]};
            default:      bus.axis_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/safety_check.sv ====
/* over-current monitor for one axis
   trips when feedback stays above twice the command, latched until cleared */
`timescale 1ns/1ns
`default_nettype none

module safety_check import qla_pkg::*; #(
    parameter int SAFETY_CYCLES = 8   // consecutive over-limit cycles to trip
) (
    input  logic sysclk,
    input  logic rst,
    input  adc_t cur_in,         // measured current
    input  adc_t dac_in,         // commanded current
    input  logic clear_disable,  // re-arm after trip
    output logic amp_disable
);

    localparam int CNT_W = (SAFETY_CYCLES > 1) ? $clog2(SAFETY_CYCLES + 1) : 1;

    typedef enum logic [1:0] {
        MONITOR,
        COUNTING,
        TRIPPED
    } safety_state_e;

    safety_state_e    state;
    logic [CNT_W-1:0] cnt;        // over-limit cycles seen so far
    logic             over_limit;

    // 17-bit compare, 2*dac must not wrap
    assign over_limit = {1'b0, cur_in} > {dac_in, 1'b0};

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= MONITOR;
            cnt   <= '0;
        end else begin
            case (state)
                MONITOR: begin
                    cnt <= CNT_W'(1);
                    if (over_limit)
                        state <= COUNTING;
                end
                COUNTING: begin
                    if (!over_limit) begin
                        state <= MONITOR;         // glitch, start over
                    end else if (cnt >= CNT_W'(SAFETY_CYCLES - 1)) begin
                        state <= TRIPPED;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TRIPPED: begin
                    if (clear_disable)
                        state <= MONITOR;         // held until host re-enables
                end
                default: state <= MONITOR;
            endcase
        end
    end

    assign amp_disable = (state == TRIPPED);

    a_disable_is_tripped: assert property (
        @(posedge sysclk) disable iff (rst) amp_disable |-> (state == TRIPPED)
    ) else $error("amp_disable outside TRIPPED");

    // trip is sticky, only clear_disable releases it
    a_trip_sticky: assert property (
        @(posedge sysclk) disable iff (rst) (amp_disable && !clear_disable) |=> amp_disable
    ) else $error("safety latch released without clear");

endmodule

`default_nettype wire

// ==== design/fpga_qla_top.sv ====
/* register core of the four-axis motor controller
   two hosts share one register bus, per-axis over-current checks gate the amps */
`timescale 1ns/1ns
`default_nettype none

module fpga_qla_top import qla_pkg::*; #(
    parameter int SAFETY_CYCLES = 8
) (
    input  logic                sysclk,
    input  logic                rst,
    input  logic [3:0]          wenid,       // rotary switch

    // serial-link host
    input  logic                fw_wen,
    input  addr_t               fw_waddr,
    input  data_t               fw_wdata,
    input  addr_t               fw_raddr,

    // network host
    input  logic                eth_wen,
    input  addr_t               eth_waddr,
    input  data_t               eth_wdata,
    input  addr_t               eth_raddr,
    input  logic                eth_read_en,

    output data_t               reg_rdata,

    input  adc_t [NUM_AXES-1:0] adc_cur,     // current feedback per axis
    input  adc_t [NUM_AXES-1:0] adc_pot,     // pot feedback per axis
    output adc_t [NUM_AXES-1:0] dac_cmd,
    output logic                pwr_en,
    output logic [NUM_AXES-1:0] amp_en
);

    logic [NUM_AXES-1:0] safety_disable;  // trips, into board regs
    logic [NUM_AXES-1:0] clear_disable;   // re-arm pulses, from board regs

    reg_bus_if u_bus (.sysclk(sysclk));

    // --------------------------------------------------
    host_arbiter u_arb (
        .sysclk      (sysclk),
        .fw_wen      (fw_wen),
        .fw_waddr    (fw_waddr),
        .fw_wdata    (fw_wdata),
        .fw_raddr    (fw_raddr),
        .eth_wen     (eth_wen),
        .eth_waddr   (eth_waddr),
        .eth_wdata   (eth_wdata),
        .eth_raddr   (eth_raddr),
        .eth_read_en (eth_read_en),
        .reg_rdata   (reg_rdata),
        .bus         (u_bus.arb)
    );

    board_regs u_board (
        .rst            (rst),
        .wenid          (wenid),
        .safety_disable (safety_disable),
        .pwr_en         (pwr_en),
        .amp_en         (amp_en),
        .clear_disable  (clear_disable),
        .bus            (u_bus.board)
    );

    axis_regs u_axis (
        .rst     (rst),
        .cur_fb  (adc_cur),
        .pot_fb  (adc_pot),
        .cur_cmd (dac_cmd),
        .bus     (u_bus.axis)
    );

    // --------------------------------------------------
    // one over-current check per axis, axis n at index n-1
    for (genvar n = 1; n <= NUM_AXES; n++) begin : u_safety
        safety_check #(
            .SAFETY_CYCLES (SAFETY_CYCLES)
        ) u_check (
            .sysclk        (sysclk),
            .rst           (rst),
            .cur_in        (adc_cur[n-1]),
            .dac_in        (dac_cmd[n-1]),
            .clear_disable (clear_disable[n-1]),
            .amp_disable   (safety_disable[n-1])
        );
    end

endmodule

`default_nettype wire

// ==== tests/tb_qla.sv ====
/* testbench for the register core, replays tests/qla_stim.txt step by step
   through both hosts and checks read data, enables and dac outputs */
`timescale 1ns/1ns
`default_nettype none

module tb_qla import qla_pkg::*; ();

    localparam int WAIT_LIMIT = 200;   // cycles before a wait gives up

    logic                sysclk;
    logic                rst;
    logic [3:0]          wenid;
    logic                fw_wen;
    addr_t               fw_waddr;
    data_t               fw_wdata;
    addr_t               fw_raddr;
    logic                eth_wen;
    addr_t               eth_waddr;
    data_t               eth_wdata;
    addr_t               eth_raddr;
    logic                eth_read_en;
    data_t               reg_rdata;
    adc_t [NUM_AXES-1:0] adc_cur;
    adc_t [NUM_AXES-1:0] adc_pot;
    adc_t [NUM_AXES-1:0] dac_cmd;
    logic                pwr_en;
    logic [NUM_AXES-1:0] amp_en;

    logic [31:0] rng;        // xorshift state

    fpga_qla_top #(
        .SAFETY_CYCLES (8)
    ) u_dut (
        .sysclk      (sysclk),
        .rst         (rst),
        .wenid       (wenid),
        .fw_wen      (fw_wen),
        .fw_waddr    (fw_waddr),
        .fw_wdata    (fw_wdata),
        .fw_raddr    (fw_raddr),
        .eth_wen     (eth_wen),
        .eth_waddr   (eth_waddr),
        .eth_wdata   (eth_wdata),
        .eth_raddr   (eth_raddr),
        .eth_read_en (eth_read_en),
        .reg_rdata   (reg_rdata),
        .adc_cur     (adc_cur),
        .adc_pot     (adc_pot),
        .dac_cmd     (dac_cmd),
        .pwr_en      (pwr_en),
        .amp_en      (amp_en)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;   // 4 ns period
    end

    // --------------------------------------------------
    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Regression failed");
            $fatal(1, "run stopped on mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // --------------------------------------------------
    // bus tasks, each starts and ends just after a falling edge
    task automatic host_write(input logic [7:0] host, input addr_t addr,
                              input data_t data, input data_t eth_data);
        if (host != "E") begin
            fw_wen   = 1'b1;
            fw_waddr = addr;
            fw_wdata = data;
        end
        if (host == "E" || host == "B") begin
            eth_wen   = 1'b1;
            eth_waddr = addr;
            eth_wdata = (host == "B") ? eth_data : data;   // B: both hosts, same cycle
        end
        @(negedge sysclk);
        fw_wen  = 1'b0;   // single-cycle strobe
        eth_wen = 1'b0;
    endtask

    task automatic host_read(input logic [7:0] host, input addr_t addr, output data_t rd);
        if (host == "E") begin
            eth_read_en = 1'b1;
            eth_raddr   = addr;
            fw_raddr    = ~addr;   // fw points elsewhere, must be ignored
        end else begin
            eth_read_en = 1'b0;
            fw_raddr    = addr;
            eth_raddr   = ~addr;
        end
        @(posedge sysclk);
        @(negedge sysclk);
        rd = reg_rdata;            // mid-cycle, stable
    endtask

    // poll status until the safety field matches, then check the gated amps
    task automatic wait_safety(input data_t exp, input data_t amp_exp);
        data_t st;
        bit    found;
        found = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !found; n++) begin
            host_read("F", 16'h0000, st);
            found = (st[STAT_SAFETY +: 4] == exp[3:0]);
        end
        if (!found)
            fail_now("timeout: status safety bits never reached the expected value");
        check("amp_en after safety wait", amp_exp, {28'h0, amp_en});
    endtask

    task automatic random_dac(input int count);
        int         axis;
        logic [7:0] host;
        adc_t       val;
        addr_t      addr;
        data_t      rd;
        for (int i = 0; i < count; i++) begin
            rng  = xorshift(rng);
            axis = int'(rng[1:0]) + 1;           // channels 1..4
            host = rng[8] ? "E" : "F";
            val  = rng[31:16];
            addr = {8'h00, 4'(axis), 4'h1};      // dac ctrl offset
            host_write(host, addr, {16'h0, val}, 32'h0);
            check("dac_cmd port", {16'h0, val}, {16'h0, dac_cmd[axis-1]});
            host_read(host, addr, rd);
            check("dac readback", {16'h0, val}, rd);
        end
    endtask

    // --------------------------------------------------
    initial begin
        int          fd;
        int          nf;
        int          lineno;
        string       line;
        logic [7:0]  op;
        logic [7:0]  host;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expv;
        data_t       rd;

        rng         = 32'd2636;
        lineno      = 0;
        rst         = 1'b1;
        wenid       = 4'hA;   // reads back as 5
        fw_wen      = 1'b0;
        fw_waddr    = '0;
        fw_wdata    = '0;
        fw_raddr    = '0;
        eth_wen     = 1'b0;
        eth_waddr   = '0;
        eth_wdata   = '0;
        eth_raddr   = '0;
        eth_read_en = 1'b0;
        adc_cur     = '0;
        adc_pot     = '0;

        repeat (16) @(posedge sysclk);
        @(negedge sysclk);
        rst = 1'b0;

        check("pwr_en after reset", 32'h0, {31'h0, pwr_en});
        check("amp_en after reset", 32'h0, {28'h0, amp_en});
        for (int i = 0; i < NUM_AXES; i++)
            check("dac_cmd after reset", 32'h0, {16'h0, dac_cmd[i]});

        fd = $fopen("tests/qla_stim.txt", "r");
        if (fd == 0)
            fail_now("could not open the stimulus file tests/qla_stim.txt");

        while (!$feof(fd)) begin
            line = "";
            nf   = $fgets(line, fd);
            lineno++;
            nf   = $sscanf(line, "%c %c %h %h %h", op, host, addr, data, expv);
            if (nf == 5 && op != "#") begin      // comments and blanks skipped
                case (op)
                    "W": host_write(host, addr[15:0], data, expv);
                    "R": begin
                        host_read(host, addr[15:0], rd);
                        check($sformatf("line %0d read %h", lineno, addr[15:0]), expv, rd);
                    end
                    "A": begin
                        adc_pot[addr-1] = data[31:16];
                        adc_cur[addr-1] = data[15:0];
                    end
                    "T": wait_safety(expv, data);
                    "X": random_dac(int'(data));
                    default: fail_now($sformatf("unknown op on stimulus line %0d", lineno));
                endcase
            end
        end
        $fclose(fd);

        // any mismatch or timeout has already stopped the run
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/qla_stim.txt ====
# op host addr data expect, hex; host F serial, E network, B both (eth writes expect), - none
# W write, R read and compare, A axis=addr data={pot,cur}, T safety==expect then amp_en==data, X n random dac writes
R F 0000 00000000 05000000
R E 0004 00000000 514C4131
X - 0000 00000010 00000000
R F 0050 00000000 00000000
R E 1011 00000000 00000000
R F 0002 00000000 00000000
W B 0021 00001111 00002222
R F 0021 00000000 00002222
R E 0021 00000000 00002222
W F 0011 00004000 00000000
W E 0021 00002000 00000000
W F 0031 00004000 00000000
W E 0041 00004000 00000000
A - 0001 12345678 00000000
R E 0010 00000000 12345678
A - 0003 9ABC0100 00000000
R F 0030 00000000 9ABC0100
W F 0000 00000505 00000000
T - 0000 00000000 00000000
W E 0000 000C0505 00000000
T - 0000 00000005 00000000
R F 0000 00000000 05040005
W F 0000 00000202 00000000
T - 0000 00000007 00000000
A - 0002 0000F000 00000000
T - 0000 00000005 00000002
R F 0000 00000000 05040207
A - 0002 00001000 00000000
W F 0000 00000202 00000000
R F 0000 00000000 05040007
T - 0000 00000007 00000000

// ==== build.f ====
design/qla_pkg.sv
design/reg_bus_if.sv
design/host_arbiter.sv
design/board_regs.sv
design/axis_regs.sv
design/safety_check.sv
design/fpga_qla_top.sv
tests/tb_qla.sv

// ==== Makefile ====
# Verilator build, run and lint for the register core testbench

VERILATOR ?= verilator
TOP       ?= tb_qla
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
